//--- fifo_flags_pkg.sv
package fifo_flags_pkg;

  // ====================================================================
  // Sizing constants for the seven-entry FIFO flag controller
  // ====================================================================

  // Number of storage entries in the external FIFO memory
  localparam int fifo_entries = 7;

  // Width of the grey counters and of the storage addresses
  localparam int ptr_width = 3;

  // Flops in each crossing between write_clk and read_clk
  localparam int sync_stages = 2;

  // ====================================================================
  // Pointer types
  // ====================================================================

  // Grey counter value that travels between the two clock domains
  // The counter has eight codes for seven entries, so that a full FIFO
  // and an empty FIFO never show the same pair of counters
  // Equal counters mean the FIFO is empty
  // The FIFO is full when the grey successor of the write counter
  // equals the read counter
  typedef logic [ptr_width-1:0] grey_ptr_t;

  // Storage address that counts 0 to 6 and wraps back to 0
  typedef logic [ptr_width-1:0] entry_addr_t;

  // ====================================================================
  // Step functions shared by both sides
  // ====================================================================

  // Next code in the grey cycle 000 001 011 010 110 111 101 100
  // Exactly one bit changes per step, which keeps the crossing safe
  // Anything outside the cycle falls back to the start code
  function automatic grey_ptr_t grey_inc(input grey_ptr_t ptr);
    grey_ptr_t next_ptr;
    case (ptr)
      3'b000: next_ptr = 3'b001;
      3'b001: next_ptr = 3'b011;
      3'b011: next_ptr = 3'b010;
      3'b010: next_ptr = 3'b110;
      3'b110: next_ptr = 3'b111;
      3'b111: next_ptr = 3'b101;
      3'b101: next_ptr = 3'b100;
      3'b100: next_ptr = 3'b000;
      default: next_ptr = 3'b000;
    endcase
    return next_ptr;
  endfunction

  // Address plus one modulo the number of entries
  // The address counts one short of the grey counter, since the eighth
  // grey code only marks the difference between full and empty
  function automatic entry_addr_t addr_inc(input entry_addr_t addr);
    entry_addr_t next_addr;
    if (addr >= entry_addr_t'(fifo_entries - 1))
    begin
      // Last entry reached, wrap to the bottom of the storage
      next_addr = '0;
    end
    else
    begin
      next_addr = addr + entry_addr_t'(1);
    end
    return next_addr;
  endfunction

endpackage

//--- grey_ptr_sync.sv
// Carries one grey pointer into the clock domain of clk
// Every bit passes through the same chain of flops, and because only one
// bit of the pointer moves per step the settled value is always either
// the old pointer or the new one, never a mix of the two
module grey_ptr_sync (
  input  logic                     clk,
  input  logic                     reset_flags_async,
  input  fifo_flags_pkg::grey_ptr_t ptr_in,
  output fifo_flags_pkg::grey_ptr_t ptr_out
);

  // ====================================================================
  // Synchronizer chain
  // ====================================================================

  // Stage 0 is the flop that may go metastable
  // The later stages give it a full receiving clock to settle
  fifo_flags_pkg::grey_ptr_t sync_q [fifo_flags_pkg::sync_stages];

  always_ff @(posedge clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      // Both pointers start at zero, so the crossed copy does too
      for (int i = 0; i < fifo_flags_pkg::sync_stages; i++)
      begin
        sync_q[i] <= '0;
      end
    end
    else
    begin
      // First stage samples the pointer from the other domain
      sync_q[0] <= ptr_in;
      // Remaining stages shift the value along the chain
      for (int i = 1; i < fifo_flags_pkg::sync_stages; i++)
      begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // The last stage is the only copy the receiving logic may look at
  assign ptr_out = sync_q[fifo_flags_pkg::sync_stages-1];

endmodule

//--- fifo_write_flags.sv
// Write side of the FIFO flag controller, clocked by write_clk
// The user writes data first and the flag follows one clock later
// A capture strobe tells the external storage to store at write_address,
// and in the next clock the grey counter and the address step forward
module fifo_write_flags (
  input  logic                        write_clk,
  input  logic                        reset_flags_async,
  input  logic                        write_submit,
  input  fifo_flags_pkg::grey_ptr_t   synced_read_ptr,
  output fifo_flags_pkg::grey_ptr_t   write_ptr,
  output fifo_flags_pkg::entry_addr_t write_address,
  output logic                        write_capture_data,
  output logic                        write_room_available,
  output logic                        write_error
);

  // ====================================================================
  // Full detection and room flag
  // ====================================================================

  // Grey code the write counter moves to once the pending entry lands
  fifo_flags_pkg::grey_ptr_t next_write_ptr;

  // High when one more entry still fits in the storage
  logic write_not_full;

  // Set for the one clock between a capture and the pointer step
  logic write_holdoff;

  assign next_write_ptr = fifo_flags_pkg::grey_inc(write_ptr);

  // The FIFO is full once one more step would catch the read counter
  // The read counter seen here lags the real one, so the check errs on
  // the side of reporting full for a little too long
  assign write_not_full = (next_write_ptr != synced_read_ptr);

  // No room while a captured entry has not yet moved the counter
  // Without the holdoff a second submit would reuse the same address
  assign write_room_available = write_not_full & ~write_holdoff;

  // Data is stored only when room is offered in the same clock
  assign write_capture_data = write_submit & write_room_available;

  // ====================================================================
  // Holdoff and error flops
  // ====================================================================

  always_ff @(posedge write_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      write_holdoff <= 1'b0;
      write_error   <= 1'b0;
    end
    else
    begin
      // A capture this clock blocks room in the next one
      write_holdoff <= write_capture_data;
      // A submit that was refused is reported for a single clock
      write_error   <= write_submit & ~write_room_available;
    end
  end

  // ====================================================================
  // Write counter and address
  // ====================================================================

  // Both step one clock after the capture, while the holdoff is set
  // The counter moves only after the data is in storage, so the read side
  // never sees an entry before it is written
  always_ff @(posedge write_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      write_ptr     <= '0;
      write_address <= '0;
    end
    else if (write_holdoff)
    begin
      write_ptr     <= next_write_ptr;
      write_address <= fifo_flags_pkg::addr_inc(write_address);
    end
  end

endmodule

//--- fifo_read_flags.sv
// Read side of the FIFO flag controller, clocked by read_clk
// The storage is read constantly at read_address, so data and the
// data-available flag turn valid in the same clock
// A remove in a clock with data available consumes the entry
module fifo_read_flags (
  input  logic                        read_clk,
  input  logic                        reset_flags_async,
  input  logic                        read_remove,
  input  fifo_flags_pkg::grey_ptr_t   synced_write_ptr,
  output fifo_flags_pkg::grey_ptr_t   read_ptr,
  output fifo_flags_pkg::entry_addr_t read_address,
  output logic                        read_data_available,
  output logic                        read_error
);

  // ====================================================================
  // Empty detection
  // ====================================================================

  // High in a clock where the user takes an entry that really exists
  logic read_accept;

  // Any difference between the counters means at least one entry waits
  // The write counter seen here moves only after the data was stored,
  // so the entry at read_address is already valid when this rises
  assign read_data_available = (read_ptr != synced_write_ptr);

  assign read_accept = read_remove & read_data_available;

  // ====================================================================
  // Read counter and address
  // ====================================================================

  // Counter and address step together on the edge that ends the remove
  // The new counter reaches the write side through its own synchronizer
  // and frees the slot there a few write clocks later
  always_ff @(posedge read_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      read_ptr     <= '0;
      read_address <= '0;
    end
    else if (read_accept)
    begin
      read_ptr     <= fifo_flags_pkg::grey_inc(read_ptr);
      read_address <= fifo_flags_pkg::addr_inc(read_address);
    end
  end

  // ====================================================================
  // Read error
  // ====================================================================

  // A remove while the FIFO looks empty changes nothing else
  // It is reported one clock later and for that one clock only
  always_ff @(posedge read_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      read_error <= 1'b0;
    end
    else
    begin
      read_error <= read_remove & ~read_data_available;
    end
  end

endmodule

//--- fifo_flags_top.sv
// Top level of the dual-clock FIFO flag controller
// The write side, the read side and the two synchronizers form a ring
// The write counter crosses to read_clk, and the read counter comes back
// across to write_clk through the second synchronizer
module fifo_flags_top (
  input  logic                        reset_flags_async,

  // Write clock domain
  input  logic                        write_clk,
  input  logic                        write_submit,
  output logic                        write_capture_data,
  output logic                        write_room_available,
  output fifo_flags_pkg::entry_addr_t write_address,
  output logic                        write_error,

  // Read clock domain
  input  logic                        read_clk,
  input  logic                        read_remove,
  output logic                        read_data_available,
  output fifo_flags_pkg::entry_addr_t read_address,
  output logic                        read_error
);

  // ====================================================================
  // Pointers around the ring
  // ====================================================================

  // Write counter in its own domain and its copy in the read domain
  fifo_flags_pkg::grey_ptr_t write_ptr;
  fifo_flags_pkg::grey_ptr_t synced_write_ptr;

  // Read counter in its own domain and its copy in the write domain
  fifo_flags_pkg::grey_ptr_t read_ptr;
  fifo_flags_pkg::grey_ptr_t synced_read_ptr;

  // Write side decides room and steps the write counter
  fifo_write_flags u_write (
    .write_clk            (write_clk),
    .reset_flags_async    (reset_flags_async),
    .write_submit         (write_submit),
    .synced_read_ptr      (synced_read_ptr),
    .write_ptr            (write_ptr),
    .write_address        (write_address),
    .write_capture_data   (write_capture_data),
    .write_room_available (write_room_available),
    .write_error          (write_error)
  );

  // Write counter into the read domain
  grey_ptr_sync u_sync_to_read (
    .clk               (read_clk),
    .reset_flags_async (reset_flags_async),
    .ptr_in            (write_ptr),
    .ptr_out           (synced_write_ptr)
  );

  // Read side decides data available and steps the read counter
  fifo_read_flags u_read (
    .read_clk            (read_clk),
    .reset_flags_async   (reset_flags_async),
    .read_remove         (read_remove),
    .synced_write_ptr    (synced_write_ptr),
    .read_ptr            (read_ptr),
    .read_address        (read_address),
    .read_data_available (read_data_available),
    .read_error          (read_error)
  );

  // Read counter back into the write domain, which closes the ring
  grey_ptr_sync u_sync_to_write (
    .clk               (write_clk),
    .reset_flags_async (reset_flags_async),
    .ptr_in            (read_ptr),
    .ptr_out           (synced_read_ptr)
  );

endmodule

//--- tb_fifo_flags_model.svh
`ifndef TB_FIFO_FLAGS_MODEL_SVH
`define TB_FIFO_FLAGS_MODEL_SVH

// ======================================================================
// Occupancy model of the external storage
// ======================================================================

// Addresses of captured entries in the order they were written
// The front of the queue is the entry the read side must present next
fifo_flags_pkg::entry_addr_t addr_queue[$];

// Number of captures seen since reset, used for the expected address
int capture_count;

// Captures minus accepted removes
int entries_in_flight;

// Ends the run after a failed check or a timeout
task automatic stop_with_failure();
  $display("STATUS: FAIL");
  $fatal(1, "simulation stopped at the first failure");
endtask

// Compares one observed value with the value the model expects
task automatic check_value(input string signal_name, input logic [31:0] actual,
                           input logic [31:0] expected);
  if (actual !== expected)
  begin
    $display("FAILED at time %0t: %s is %0d, expected %0d",
             $time, signal_name, actual, expected);
    stop_with_failure();
  end
endtask

// Reports a wait that ran past its limit
task automatic stop_on_timeout(input string what);
  $display("Timeout at time %0t: %s", $time, what);
  stop_with_failure();
endtask

// A capture must land at the next address in the modulo-7 sequence
task automatic record_capture(input fifo_flags_pkg::entry_addr_t addr);
  check_value("write_address", addr, capture_count % fifo_flags_pkg::fifo_entries);
  addr_queue.push_back(addr);
  capture_count++;
  entries_in_flight++;
  // The storage has only seven slots, so an eighth entry is an overflow
  check_value("entries_in_flight_within_depth",
              entries_in_flight <= fifo_flags_pkg::fifo_entries, 1);
endtask

// An accepted remove must read the oldest entry still in storage
task automatic take_entry(input fifo_flags_pkg::entry_addr_t addr);
  check_value("read_address", addr, addr_queue[0]);
  addr_queue.pop_front();
  entries_in_flight--;
endtask

`endif

//--- tb_fifo_flags.sv
module tb_fifo_flags;

  // ====================================================================
  // DUT connections and stimulus state
  // ====================================================================

  logic                        reset_flags_async;
  logic                        write_clk;
  logic                        write_submit;
  logic                        write_capture_data;
  logic                        write_room_available;
  fifo_flags_pkg::entry_addr_t write_address;
  logic                        write_error;
  logic                        read_clk;
  logic                        read_remove;
  logic                        read_data_available;
  fifo_flags_pkg::entry_addr_t read_address;
  logic                        read_error;

  // State of the 16-bit Fibonacci LFSR behind all random choices
  logic [15:0] lfsr_state;

  // Set once the write side stops submitting
  logic writes_done;

  // Set by the read side when the FIFO has emptied after the writes
  logic drain_done;

  `include "tb_fifo_flags_model.svh"

  fifo_flags_top dut (
    .reset_flags_async    (reset_flags_async),
    .write_clk            (write_clk),
    .write_submit         (write_submit),
    .write_capture_data   (write_capture_data),
    .write_room_available (write_room_available),
    .write_address        (write_address),
    .write_error          (write_error),
    .read_clk             (read_clk),
    .read_remove          (read_remove),
    .read_data_available  (read_data_available),
    .read_address         (read_address),
    .read_error           (read_error)
  );

  // Read clock with period 100
  initial
  begin
    read_clk = 1'b0;
    forever #50 read_clk = ~read_clk;
  end

  // Write clock with period 70
  // The small start offset keeps its falling edges apart from read_clk
  initial
  begin
    write_clk = 1'b0;
    #3;
    forever #35 write_clk = ~write_clk;
  end

  // ====================================================================
  // Random numbers
  // ====================================================================

  // One LFSR step with taps 16 14 13 11, returning the new bit
  function automatic logic random_bit();
    logic feedback;
    feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], feedback};
    return feedback;
  endfunction

  // Builds a small number from count fresh LFSR bits
  function automatic int random_bits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++)
    begin
      value = (value << 1) | int'(random_bit());
    end
    return value;
  endfunction

  // ====================================================================
  // Write side stimulus and checks
  // ====================================================================

  task automatic drive_write_side();
    int   active_cycles;
    int   idle_cycles;
    logic room;
    logic submit;
    logic capture;
    logic expect_error;
    logic prev_capture;
    active_cycles = 0;
    idle_cycles   = 0;
    expect_error  = 1'b0;
    prev_capture  = 1'b0;
    while (!drain_done)
    begin
      @(negedge write_clk);
      // Room comes from flops only, so it holds until the next rising edge
      room = write_room_available;
      check_value("write_error", write_error, expect_error);
      // The clock after a capture is the holdoff clock
      if (prev_capture)
      begin
        check_value("write_room_available", room, 0);
      end
      if (active_cycles < 400)
      begin
        // About 60 percent while room is offered, rarely a submit against a full flag
        if (room)
        begin
          submit = (random_bits(4) < 10);
        end
        else
        begin
          submit = (random_bits(4) == 0);
        end
        active_cycles++;
      end
      else
      begin
        submit      = 1'b0;
        writes_done = 1'b1;
        idle_cycles++;
        if (idle_cycles > 600)
        begin
          stop_on_timeout("read side never reported the FIFO drained");
        end
      end
      write_submit = submit;
      #1;
      // A submit is taken only in a clock that offers room
      // In the holdoff clock room is low, so no capture may appear there
      capture = submit & room;
      check_value("write_capture_data", write_capture_data, capture);
      if (capture)
      begin
        record_capture(write_address);
      end
      expect_error = submit & ~room;
      prev_capture = capture;
    end
    write_submit = 1'b0;
  endtask

  // ====================================================================
  // Read side stimulus and checks
  // ====================================================================

  task automatic drive_read_side();
    int   read_cycles;
    logic available;
    logic remove;
    logic expect_error;
    read_cycles  = 0;
    expect_error = 1'b0;
    while (!drain_done)
    begin
      @(negedge read_clk);
      read_cycles++;
      if (read_cycles > 600)
      begin
        stop_on_timeout("FIFO did not drain after the writes stopped");
      end
      available = read_data_available;
      check_value("read_error", read_error, expect_error);
      // Data may never be offered while the model holds nothing
      if (addr_queue.size() == 0)
      begin
        check_value("read_data_available", available, 0);
      end
      if (writes_done && (addr_queue.size() == 0) && !available)
      begin
        remove     = 1'b0;
        drain_done = 1'b1;
      end
      else if (writes_done)
      begin
        // Reads stay on until the last entry has crossed and been taken
        remove = 1'b1;
      end
      else
      begin
        remove = random_bit();
      end
      read_remove = remove;
      if (remove && available)
      begin
        take_entry(read_address);
      end
      expect_error = remove & ~available;
    end
    read_remove = 1'b0;
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================

  initial
  begin
    lfsr_state        = 16'd29576;
    writes_done       = 1'b0;
    drain_done        = 1'b0;
    capture_count     = 0;
    entries_in_flight = 0;
    write_submit      = 1'b0;
    read_remove       = 1'b0;
    reset_flags_async = 1'b1;

    // Reset spans two read clocks and is released on a falling edge
    repeat (2) @(negedge read_clk);
    reset_flags_async = 1'b0;
    #1;

    check_value("write_address", write_address, 0);
    check_value("read_address", read_address, 0);
    check_value("write_capture_data", write_capture_data, 0);
    check_value("write_error", write_error, 0);
    check_value("read_data_available", read_data_available, 0);
    check_value("read_error", read_error, 0);
    check_value("write_room_available", write_room_available, 1);

    fork
      drive_write_side();
      drive_read_side();
    join

    // A drained FIFO has both addresses back in step at the next free entry
    check_value("write_address", write_address,
                capture_count % fifo_flags_pkg::fifo_entries);
    check_value("read_address", read_address,
                capture_count % fifo_flags_pkg::fifo_entries);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
fifo_flags_pkg.sv
grey_ptr_sync.sv
fifo_write_flags.sv
fifo_read_flags.sv
fifo_flags_top.sv
tb_fifo_flags.sv
